//--- rtl/issue_pkg.sv
package issue_pkg;

	// Number of hardware threads sharing the issue slot
	localparam int num_threads = 4;

	// Scalar registers visible to each thread
	localparam int num_regs = 16;

	// Entries in each per-thread instruction FIFO
	localparam int fifo_depth = 5;

	// Fetch enable drops at this occupancy, leaving room for two instructions in flight
	localparam int almost_full_level = 3;

	// Cycles from the issue register to the writeback register, per pipeline
	localparam int lat_single = 1;
	localparam int lat_mem = 2;
	localparam int lat_multi = 4;

	// Future writeback slots that can be claimed by an earlier, longer instruction
	localparam int wb_alloc_depth = lat_multi - 1;

	// Number of execution pipelines merging into writeback
	localparam int num_pipelines = 3;

	typedef logic [$clog2(num_threads)-1:0] thread_idx_t;
	typedef logic [$clog2(num_regs)-1:0] reg_idx_t;
	typedef logic [num_regs-1:0] reg_bitmap_t;
	typedef logic [7:0] instr_tag_t;
	typedef logic [$clog2(fifo_depth)-1:0] fifo_ptr_t;
	typedef logic [$clog2(fifo_depth + 1)-1:0] fifo_count_t;

	typedef enum logic [1:0]
	{
		pipe_single,
		pipe_mem,
		pipe_multi
	} pipeline_sel_t;

	typedef struct packed
	{
		instr_tag_t tag;
		pipeline_sel_t pipeline;
		logic has_dest;
		reg_idx_t dest_reg;
		logic has_src1;
		reg_idx_t src1_reg;
		logic has_src2;
		reg_idx_t src2_reg;
	} decoded_instr_t;

	typedef struct packed
	{
		logic valid;
		thread_idx_t thread;
		decoded_instr_t instr;
	} writeback_t;

	// Latency of a pipeline from issue to writeback
	function automatic int pipe_latency(pipeline_sel_t pipe);
		case (pipe)
			pipe_single: return lat_single;
			pipe_mem: return lat_mem;
			default: return lat_multi;
		endcase
	endfunction

endpackage

//--- rtl/instruction_fifo.sv
module instruction_fifo import issue_pkg::*; (
	input logic clk,
	input logic reset,
	input logic enqueue_en,
	input decoded_instr_t value_in,
	input logic dequeue_en,
	output decoded_instr_t value_out,
	output logic empty,
	output logic almost_full
);

	decoded_instr_t storage[fifo_depth];
	fifo_ptr_t head;
	fifo_ptr_t tail;
	fifo_count_t count;

	// The depth need not be a power of two, so pointers wrap explicitly
	function automatic fifo_ptr_t wrap_inc(fifo_ptr_t ptr);
		if (ptr == fifo_ptr_t'(fifo_depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Oldest entry is always presented to the scoreboard and arbiter
	assign value_out = storage[head];
	assign empty = count == '0;

	// Derived from the count so the flag tracks enqueues one cycle later
	assign almost_full = count >= fifo_count_t'(almost_full_level);

	always_ff @(posedge clk)
	begin
		if (enqueue_en)
			storage[tail] <= value_in;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			if (enqueue_en)
				tail <= wrap_inc(tail);

			if (dequeue_en)
				head <= wrap_inc(head);

			// Simultaneous enqueue and dequeue leaves the count alone
			case ({enqueue_en, dequeue_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- rtl/rr_arbiter.sv
module rr_arbiter import issue_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [num_threads-1:0] request,
	output logic [num_threads-1:0] grant_oh
);

	// Index of the most recently granted requester
	thread_idx_t last_grant;
	thread_idx_t grant_idx;
	logic grant_any;

	// Search starts just past the last winner and wraps around once
	always_comb
	begin
		grant_oh = '0;
		grant_idx = last_grant;
		grant_any = 1'b0;
		for (int offset = 1; offset <= num_threads; offset++)
		begin
			if (!grant_any && request[(int'(last_grant) + offset) % num_threads])
			begin
				grant_any = 1'b1;
				grant_idx = thread_idx_t'((int'(last_grant) + offset) % num_threads);
				grant_oh[grant_idx] = 1'b1;
			end
		end
	end

	// Thread 0 wins first after reset
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_grant <= thread_idx_t'(num_threads - 1);
		else if (grant_any)
			last_grant <= grant_idx;
	end

endmodule

//--- rtl/thread_scoreboard.sv
module thread_scoreboard import issue_pkg::*; (
	input logic clk,
	input logic reset,
	input decoded_instr_t next_instr,
	input logic issue_en,
	input logic clear_en,
	input reg_idx_t clear_reg,
	output logic hazard
);

	// One bit per register with a result still in flight
	reg_bitmap_t pending;
	reg_bitmap_t dest_bitmap;
	reg_bitmap_t src_bitmap;
	reg_bitmap_t clear_bitmap;
	reg_bitmap_t pending_nxt;

	function automatic reg_bitmap_t reg_to_bitmap(logic en, reg_idx_t idx);
		if (en)
			return reg_bitmap_t'(1) << idx;
		return '0;
	endfunction

	// Destination of the head instruction, also the bit set when it issues
	assign dest_bitmap = reg_to_bitmap(next_instr.has_dest, next_instr.dest_reg);

	assign src_bitmap = reg_to_bitmap(next_instr.has_src1, next_instr.src1_reg)
		| reg_to_bitmap(next_instr.has_src2, next_instr.src2_reg);

	assign clear_bitmap = reg_to_bitmap(clear_en, clear_reg);

	// Sources catch RAW hazards
	// The destination catches WAW, and with in-order issue per thread it also
	// keeps a younger write from overtaking an older read
	assign hazard = |(pending & (src_bitmap | dest_bitmap));

	// An issuing instruction never targets a pending register, so a set and
	// a clear of the same bit cannot meet in one cycle
	always_comb
	begin
		pending_nxt = pending & ~clear_bitmap;
		if (issue_en)
			pending_nxt = pending_nxt | dest_bitmap;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			pending <= '0;
		else
			pending <= pending_nxt;
	end

endmodule

//--- rtl/thread_select_stage.sv
module thread_select_stage import issue_pkg::*; (
	input logic clk,
	input logic reset,
	input logic id_valid,
	input thread_idx_t id_thread,
	input decoded_instr_t id_instr,
	input logic [num_threads-1:0] thread_enable,
	output logic [num_threads-1:0] fetch_en,
	output logic issue_valid,
	output thread_idx_t issue_thread,
	output decoded_instr_t issue_instr,
	input writeback_t wb
);

	decoded_instr_t head_instr[num_threads];
	logic [num_threads-1:0] can_issue;
	logic [num_threads-1:0] grant_oh;
	thread_idx_t grant_thread;
	decoded_instr_t grant_instr;

	// Bit j set means the writeback register is taken j + 2 cycles from now
	logic [wb_alloc_depth-1:0] wb_alloc;
	logic [wb_alloc_depth-1:0] wb_alloc_nxt;

	for (genvar t = 0; t < num_threads; t++)
	begin : thread_logic
		logic fifo_empty;
		logic fifo_almost_full;
		logic sb_hazard;
		logic wb_conflict;

		instruction_fifo thread_fifo (
			.clk(clk),
			.reset(reset),
			.enqueue_en(id_valid && id_thread == thread_idx_t'(t)),
			.value_in(id_instr),
			.dequeue_en(grant_oh[t]),
			.value_out(head_instr[t]),
			.empty(fifo_empty),
			.almost_full(fifo_almost_full)
		);

		// Writeback releases the destination on the same edge it leaves wb
		thread_scoreboard thread_sb (
			.clk(clk),
			.reset(reset),
			.next_instr(head_instr[t]),
			.issue_en(grant_oh[t]),
			.clear_en(wb.valid && wb.thread == thread_idx_t'(t) && wb.instr.has_dest),
			.clear_reg(wb.instr.dest_reg),
			.hazard(sb_hazard)
		);

		// Selected now, the head would reach wb latency + 1 cycles later
		// The longest pipeline lands past every claimed slot and never conflicts
		always_comb
		begin
			wb_conflict = 1'b0;
			for (int j = 0; j < wb_alloc_depth; j++)
			begin
				if (j == pipe_latency(head_instr[t].pipeline) - 1)
					wb_conflict = wb_alloc[j];
			end
		end

		// Dropping at almost full covers the instructions already on their way
		assign fetch_en[t] = thread_enable[t] && !fifo_almost_full;

		assign can_issue[t] = !fifo_empty && thread_enable[t] && !sb_hazard && !wb_conflict;
	end

	rr_arbiter thread_arbiter (
		.clk(clk),
		.reset(reset),
		.request(can_issue),
		.grant_oh(grant_oh)
	);

	// At most one grant bit is set
	always_comb
	begin
		grant_thread = '0;
		for (int i = 0; i < num_threads; i++)
		begin
			if (grant_oh[i])
				grant_thread = thread_idx_t'(i);
		end
	end

	assign grant_instr = head_instr[grant_thread];

	// Age the claims by one cycle and record the slot of the new issue
	// A single-cycle instruction lands before any later issue can, so it claims nothing
	always_comb
	begin
		wb_alloc_nxt = wb_alloc >> 1;
		for (int j = 0; j < wb_alloc_depth; j++)
		begin
			if (|grant_oh && j == pipe_latency(grant_instr.pipeline) - 2)
				wb_alloc_nxt[j] = 1'b1;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb_alloc <= '0;
			issue_valid <= 1'b0;
		end
		else
		begin
			wb_alloc <= wb_alloc_nxt;
			issue_valid <= |grant_oh;
		end
	end

	// Only meaningful while issue_valid is high
	always_ff @(posedge clk)
	begin
		issue_thread <= grant_thread;
		issue_instr <= grant_instr;
	end

endmodule

//--- rtl/exec_pipelines.sv
module exec_pipelines import issue_pkg::*; (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input thread_idx_t issue_thread,
	input decoded_instr_t issue_instr,
	output writeback_t wb
);

	// Last stage of each chain, feeding the shared writeback register
	writeback_t chain_out[num_pipelines];
	writeback_t wb_nxt;

	for (genvar p = 0; p < num_pipelines; p++)
	begin : chain
		localparam pipeline_sel_t this_pipe = pipeline_sel_t'(p);
		localparam int depth = pipe_latency(this_pipe);

		writeback_t chain_in;

		// Only instructions steered to this pipeline enter the chain
		assign chain_in = '{
			valid: issue_valid && issue_instr.pipeline == this_pipe,
			thread: issue_thread,
			instr: issue_instr
		};

		// The writeback register is the final stage of every chain
		if (depth == 1)
		begin : direct
			assign chain_out[p] = chain_in;
		end
		else
		begin : delay
			writeback_t stage[depth - 1];

			// Several instructions can be in flight along the chain
			always_ff @(posedge clk, posedge reset)
			begin
				if (reset)
				begin
					for (int i = 0; i < depth - 1; i++)
						stage[i].valid <= 1'b0;
				end
				else
				begin
					stage[0] <= chain_in;
					for (int i = 1; i < depth - 1; i++)
						stage[i] <= stage[i - 1];
				end
			end

			assign chain_out[p] = stage[depth - 2];
		end
	end

	// The select stage guarantees at most one chain output is valid per cycle
	always_comb
	begin
		wb_nxt = '0;
		for (int i = 0; i < num_pipelines; i++)
		begin
			if (chain_out[i].valid)
				wb_nxt = chain_out[i];
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			wb.valid <= 1'b0;
		else
			wb <= wb_nxt;
	end

endmodule

//--- rtl/issue_core.sv
module issue_core import issue_pkg::*; (
	input logic clk,
	input logic reset,
	input logic id_valid,
	input thread_idx_t id_thread,
	input decoded_instr_t id_instr,
	input logic [num_threads-1:0] thread_enable,
	output logic [num_threads-1:0] fetch_en,
	output logic issue_valid,
	output thread_idx_t issue_thread,
	output decoded_instr_t issue_instr,
	output writeback_t wb
);

	// Picks one ready thread per cycle and holds the issue register
	thread_select_stage select_stage (
		.clk(clk),
		.reset(reset),
		.id_valid(id_valid),
		.id_thread(id_thread),
		.id_instr(id_instr),
		.thread_enable(thread_enable),
		.fetch_en(fetch_en),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.issue_instr(issue_instr),
		.wb(wb)
	);

	// Writeback also returns to the select stage to release scoreboard bits
	exec_pipelines pipelines (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.issue_instr(issue_instr),
		.wb(wb)
	);

endmodule

//--- verif/tb_clock.sv
module tb_clock (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	// Toggles every 2 ns for a 4 ns period, first rising edge at 2 ns
	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

endmodule

//--- verif/issue_core_assertions.sv
module issue_core_assertions import issue_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [num_threads-1:0] thread_enable,
	input logic [num_threads-1:0] fetch_en,
	input logic issue_valid,
	input thread_idx_t issue_thread,
	input decoded_instr_t issue_instr,
	input writeback_t wb
);
	timeunit 1ns;
	timeprecision 100ps;

	// Issue to writeback delay in cycles, indexed by the pipeline field
	localparam int delay_of[num_pipelines] = '{lat_single, lat_mem, lat_multi};

	int fail_count = 0;
	int issue_delay;

	// Reference state, built only from what the DUT shows on its ports
	reg_bitmap_t [num_threads-1:0] pending;
	instr_tag_t [num_threads-1:0] last_tag;
	logic [num_threads-1:0] tag_seen;
	logic [num_threads-1:0] enable_prev;

	// Element 0 holds the writeback expected at the current edge
	writeback_t [lat_multi-1:0] expected_wb;

	// Every register the instruction reads or writes
	function automatic reg_bitmap_t touched_regs(decoded_instr_t instr);
		reg_bitmap_t bits;
		bits = '0;
		if (instr.has_dest)
			bits[instr.dest_reg] = 1'b1;
		if (instr.has_src1)
			bits[instr.src1_reg] = 1'b1;
		if (instr.has_src2)
			bits[instr.src2_reg] = 1'b1;
		return bits;
	endfunction

	// Logs the failed check with its time and keeps a running count
	task automatic record_failure(string what);
		fail_count++;
		$error("ERROR %0t: %s", $time, what);
	endtask

	assign issue_delay = delay_of[issue_instr.pipeline];

	// An issue seen at this edge is due on wb issue_delay edges later
	// The enable seen one edge earlier is the one the arbiter used
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			pending <= '0;
			last_tag <= '0;
			tag_seen <= '0;
			enable_prev <= '0;
			expected_wb <= '0;
		end
		else
		begin
			enable_prev <= thread_enable;
			expected_wb <= expected_wb >> $bits(writeback_t);
			if (wb.valid && wb.instr.has_dest)
				pending[wb.thread][wb.instr.dest_reg] <= 1'b0;
			if (issue_valid)
			begin
				expected_wb[issue_delay - 1] <= '{valid: 1'b1, thread: issue_thread,
					instr: issue_instr};
				if (issue_instr.has_dest)
					pending[issue_thread][issue_instr.dest_reg] <= 1'b1;
				last_tag[issue_thread] <= issue_instr.tag;
				tag_seen[issue_thread] <= 1'b1;
			end
		end
	end

	// Outputs are still quiet on the first edge after reset lets go
	assert property (@(posedge clk) $fell(reset) |-> !issue_valid && !wb.valid && fetch_en == '0)
		else record_failure("issue, writeback or fetch enable active right after reset");

	// Tags of one thread only grow, so nothing overtakes or repeats
	assert property (@(posedge clk) disable iff (reset)
		issue_valid |-> !tag_seen[issue_thread] || issue_instr.tag > last_tag[issue_thread])
		else record_failure("thread issued a tag out of enqueue order");

	assert property (@(posedge clk) disable iff (reset)
		issue_valid |-> enable_prev[issue_thread])
		else record_failure("a disabled thread issued an instruction");

	// Covers RAW, WAW and WAR against results still in flight
	assert property (@(posedge clk) disable iff (reset)
		issue_valid |-> (pending[issue_thread] & touched_regs(issue_instr)) == '0)
		else record_failure("issued instruction touches a pending register");

	assert property (@(posedge clk) disable iff (reset)
		wb.valid == expected_wb[0].valid && (!wb.valid || wb == expected_wb[0]))
		else record_failure("writeback does not match the issue due at this cycle");

	assert property (@(posedge clk) disable iff (reset)
		(fetch_en & ~thread_enable) == '0)
		else record_failure("fetch enable high for a disabled thread");

endmodule

bind issue_core issue_core_assertions assertions_inst (
	.clk(clk),
	.reset(reset),
	.thread_enable(thread_enable),
	.fetch_en(fetch_en),
	.issue_valid(issue_valid),
	.issue_thread(issue_thread),
	.issue_instr(issue_instr),
	.wb(wb)
);

//--- verif/issue_core_tb.sv
module issue_core_tb import issue_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_instrs = 200;
	localparam int stim_limit = 4000;
	localparam int drain_limit = 500;

	// This thread is switched off for part of the middle band of sends
	localparam int toggled_thread = 2;

	logic clk;
	logic reset;
	logic id_valid;
	thread_idx_t id_thread;
	decoded_instr_t id_instr;
	logic [num_threads-1:0] thread_enable;
	logic [num_threads-1:0] fetch_en;
	logic issue_valid;
	thread_idx_t issue_thread;
	decoded_instr_t issue_instr;
	writeback_t wb;

	integer seed = 32'h6a2e;
	instr_tag_t next_tag[num_threads];
	int sent;
	int wait_cycles;
	int thread_pick;
	int written_back = 0;

	tb_clock clock_gen (
		.clk(clk)
	);

	issue_core issue_core_inst (
		.clk(clk),
		.reset(reset),
		.id_valid(id_valid),
		.id_thread(id_thread),
		.id_instr(id_instr),
		.thread_enable(thread_enable),
		.fetch_en(fetch_en),
		.issue_valid(issue_valid),
		.issue_thread(issue_thread),
		.issue_instr(issue_instr),
		.wb(wb)
	);

	// Registers come from r0 to r3 only, so hazards show up often
	function automatic decoded_instr_t random_instr(instr_tag_t tag);
		decoded_instr_t instr;
		instr.tag = tag;
		instr.pipeline = pipeline_sel_t'($unsigned($random(seed)) % 3);
		instr.has_dest = ($random(seed) & 1) != 0;
		instr.dest_reg = reg_idx_t'($unsigned($random(seed)) % 4);
		instr.has_src1 = ($random(seed) & 1) != 0;
		instr.src1_reg = reg_idx_t'($unsigned($random(seed)) % 4);
		instr.has_src2 = ($random(seed) & 1) != 0;
		instr.src2_reg = reg_idx_t'($unsigned($random(seed)) % 4);
		return instr;
	endfunction

	// First open thread at or after a random start, or -1 when all are closed
	function automatic int pick_thread(logic [num_threads-1:0] open);
		int start;
		int pick;
		start = $unsigned($random(seed)) % num_threads;
		pick = -1;
		for (int i = num_threads - 1; i >= 0; i--)
		begin
			if (open[(start + i) % num_threads])
				pick = (start + i) % num_threads;
		end
		return pick;
	endfunction

	// Writebacks are counted on the falling edge, where wb is stable
	always @(negedge clk)
	begin
		if (!reset && wb.valid)
			written_back++;
	end

	always @(issue_core_inst.assertions_inst.fail_count)
	begin
		if (issue_core_inst.assertions_inst.fail_count != 0)
		begin
			$display("Something failed");
			$fatal(1, "A check on the issue stage failed");
		end
	end

	initial
	begin
		reset = 1'b1;
		id_valid = 1'b0;
		id_thread = '0;
		id_instr = '0;
		thread_enable = '0;
		sent = 0;
		wait_cycles = 0;
		for (int t = 0; t < num_threads; t++)
			next_tag[t] = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// Threads stay off over the first edge out of reset
		@(posedge clk);
		#1;
		thread_enable = '1;

		// Enqueue only to threads whose fetch enable is high right now
		while (sent < num_instrs && wait_cycles < stim_limit)
		begin
			@(posedge clk);
			#1;
			wait_cycles++;

			// The thread goes off right after it takes an instruction, so its
			// FIFO still holds work for the whole time it is disabled
			if (sent >= 130)
				thread_enable[toggled_thread] = 1'b1;
			else if (sent >= 80 && id_valid && id_thread == thread_idx_t'(toggled_thread))
				thread_enable[toggled_thread] = 1'b0;

			id_valid = 1'b0;
			thread_pick = pick_thread(fetch_en & thread_enable);
			if (thread_pick >= 0 && ($random(seed) & 3) != 0)
			begin
				id_valid = 1'b1;
				id_thread = thread_idx_t'(thread_pick);
				id_instr = random_instr(next_tag[thread_pick]);
				next_tag[thread_pick]++;
				sent++;
			end
		end

		if (sent < num_instrs)
		begin
			$display("Something failed");
			$fatal(1, "Stimulus timed out after sending %0d of %0d instructions",
				sent, num_instrs);
		end
		else
		begin
			// Drain until every tag has come back on wb
			wait_cycles = 0;
			while (written_back < num_instrs && wait_cycles < drain_limit)
			begin
				@(posedge clk);
				#1;
				id_valid = 1'b0;
				wait_cycles++;
			end
			if (written_back == num_instrs && issue_core_inst.assertions_inst.fail_count == 0)
			begin
				$display("Everything OK");
				$finish;
			end
			else
			begin
				$display("Something failed");
				$fatal(1, "Drain ended with %0d of %0d instructions written back",
					written_back, num_instrs);
			end
		end
	end

endmodule

//--- sources.f
rtl/issue_pkg.sv
rtl/instruction_fifo.sv
rtl/rr_arbiter.sv
rtl/thread_scoreboard.sv
rtl/thread_select_stage.sv
rtl/exec_pipelines.sv
rtl/issue_core.sv
verif/tb_clock.sv
verif/issue_core_assertions.sv
verif/issue_core_tb.sv

//--- Bender.yml
package:
  name: issue_core

sources:
  - files:
      - rtl/issue_pkg.sv
      - rtl/instruction_fifo.sv
      - rtl/rr_arbiter.sv
      - rtl/thread_scoreboard.sv
      - rtl/thread_select_stage.sv
      - rtl/exec_pipelines.sv
      - rtl/issue_core.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/issue_core_assertions.sv
      - verif/issue_core_tb.sv
